// File: common/md_cfg.svh
/*
 * Configuration macros for the cell-list position store
 *   Coordinate and cell id widths
 *   Grid size per axis, cells numbered from 1
 *   Cell capacity and cell memory address width
 */
`ifndef MD_CFG_SVH
`define MD_CFG_SVH

// One coordinate of a particle position
`define MD_COORD_W 16

// One axis of a cell id
`define MD_CELL_ID_W 4

// Grid size, 2x2x1 cells
`define MD_GRID_X 2
`define MD_GRID_Y 2
`define MD_GRID_Z 1

// Particles per cell, address 0 keeps the count
`define MD_CELL_CAP 12
`define MD_ADDR_W 4

`endif

// File: common/md_types_pkg.sv
/*
 * Particle data types
 *   pos_t        position as {z, y, x}
 *   cell_id_t    cell id as {cell_x, cell_y, cell_z}
 *   cache_word_u memory word, count at address 0 or position elsewhere
 */
`include "md_cfg.svh"

package md_types_pkg;

	// Position, z in the top bits
	typedef struct packed {
		logic [`MD_COORD_W-1:0] z;
		logic [`MD_COORD_W-1:0] y;
		logic [`MD_COORD_W-1:0] x;
	} pos_t;

	// Cell id, cell_x in the top bits
	typedef struct packed {
		logic [`MD_CELL_ID_W-1:0] cell_x;
		logic [`MD_CELL_ID_W-1:0] cell_y;
		logic [`MD_CELL_ID_W-1:0] cell_z;
	} cell_id_t;

	// Count word, zero padded up to the position width
	typedef struct packed {
		logic [3*`MD_COORD_W-`MD_ADDR_W-1:0] pad;
		logic [`MD_ADDR_W-1:0] count;
	} count_word_t;

	// Same memory word, decoded by address
	typedef union packed {
		pos_t pos;
		count_word_t cnt;
	} cache_word_u;

endpackage

// File: common/cache_ctrl_pkg.sv
/*
 * Cache control types
 *   mu_state_e  motion update state machine
 *   buf_sel_t   front buffer select
 */
package cache_ctrl_pkg;

	// Motion update states
	// Flush covers write_count and swap
	typedef enum logic [1:0] {
		st_idle        = 2'd0,
		st_collect     = 2'd1,
		st_write_count = 2'd2,
		st_swap        = 2'd3
	} mu_state_e;

	// Index of the buffer that serves reads
	typedef logic buf_sel_t;

endpackage

// File: common/mu_bus_if.sv
/*
 * Motion update broadcast bus
 *   One source at the top level, one sink per cell cache
 *   beat is already qualified by valid, ready and enable
 */
`timescale 1ns/1ns

interface mu_bus_if
	import md_types_pkg::*;
();
	// High for a whole update round
	logic enable;
	// One particle transfers this cycle
	logic beat;
	// Moved particle and the cell it lands in
	pos_t data;
	cell_id_t dst;

	modport src (
		output enable, beat, data, dst
	);

	modport sink (
		input enable, beat, data, dst
	);

endinterface

// File: pos_cache/cell_ram.sv
/*
 * Single-port synchronous cell memory
 *   Count plus capacity words, cleared at start
 *   One cycle from rden to q, q holds otherwise
 */
`timescale 1ns/1ns
`include "md_cfg.svh"

module cell_ram
	import md_types_pkg::*;
(
	input logic clk,
	input logic [`MD_ADDR_W-1:0] address,
	input cache_word_u data,
	input logic wren,
	input logic rden,
	output cache_word_u q
);

	// Address 0 for the count, then one word per particle
	localparam int depth = `MD_CELL_CAP + 1;

	cache_word_u mem [depth];

	// Both buffers start empty
	initial
	begin
		for (int i = 0; i < depth; i++)
			mem[i] = '0;
	end

	always @(posedge clk)
	begin
		if (wren && (address < depth))
			mem[address] <= data;
		// Addresses past the capacity read as zero
		if (rden)
			q <= (address < depth) ? mem[address] : '0;
	end

endmodule

// File: pos_cache/pos_cache.sv
/*
 * Per-cell double-buffered position cache
 *   Reads served from the front buffer, one cycle latency
 *   Motion update FSM fills the back buffer from the broadcast bus
 *   Count written to address 0, then the buffers swap
 */
`timescale 1ns/1ns
`include "md_cfg.svh"

module pos_cache
	import md_types_pkg::*;
	import cache_ctrl_pkg::*;
#(
	parameter int my_x = 1,
	parameter int my_y = 1,
	parameter int my_z = 1
)
(
	input logic clk,
	input logic rst,
	mu_bus_if.sink mu,
	input logic rden,
	input logic [`MD_ADDR_W-1:0] rd_addr,
	output cache_word_u q,
	output logic flushing
);

	// Own cell id, compared against every beat
	localparam cell_id_t my_id = '{
		cell_x: `MD_CELL_ID_W'(my_x),
		cell_y: `MD_CELL_ID_W'(my_y),
		cell_z: `MD_CELL_ID_W'(my_z)
	};
	// Counter value once the cell is full
	localparam logic [`MD_ADDR_W-1:0] cap_end = `MD_ADDR_W'(`MD_CELL_CAP + 1);

	mu_state_e state;
	buf_sel_t buf_sel;
	buf_sel_t rd_sel;
	// Next free particle address, starts at 1
	logic [`MD_ADDR_W-1:0] wr_cnt;
	logic wr_en;
	logic [`MD_ADDR_W-1:0] wr_addr;
	cache_word_u wr_data;
	logic take;
	cache_word_u ram_q [2];

	assign flushing = (state == st_write_count) || (state == st_swap);

	// Beat for this cell with room left, extra beats are dropped
	assign take = mu.beat && (mu.dst == my_id) && (wr_cnt != cap_end) && !flushing;

	//////////////////////////////////////////////////
	// Update control FSM
	//////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= st_idle;
			buf_sel <= 1'b0;
			wr_cnt <= `MD_ADDR_W'(1);
			wr_en <= 1'b0;
		end
		else
		begin
			// Particle write, or the count write leaving write_count
			wr_en <= take || (state == st_write_count);
			if (take)
				wr_cnt <= wr_cnt + 1'b1;
			case (state)
				st_idle:
				begin
					if (mu.enable)
						state <= st_collect;
				end
				st_collect:
				begin
					// Round ends on the first low enable
					if (!mu.enable)
						state <= st_write_count;
				end
				st_write_count:
				begin
					state <= st_swap;
				end
				st_swap:
				begin
					// Count lands in the back buffer on this same edge
					buf_sel <= ~buf_sel;
					wr_cnt <= `MD_ADDR_W'(1);
					state <= st_idle;
				end
				default:
				begin
					state <= st_idle;
				end
			endcase
		end
	end

	// Write pipeline, one cycle from beat to memory
	always_ff @(posedge clk)
	begin
		if (state == st_write_count)
		begin
			wr_addr <= '0;
			wr_data.cnt <= '{pad: '0, count: wr_cnt - 1'b1};
		end
		else
		begin
			wr_addr <= wr_cnt;
			wr_data.pos <= mu.data;
		end
	end

	// Remember which buffer a read went to
	always_ff @(posedge clk)
	begin
		if (rst)
			rd_sel <= 1'b0;
		else if (rden)
			rd_sel <= buf_sel;
	end

	//////////////////////////////////////////////////
	// Two cell memories
	//////////////////////////////////////////////////
	for (genvar b = 0; b < 2; b++)
	begin : g_buf
		logic back;

		// Back buffer takes writes, front buffer takes reads
		assign back = (buf_sel != buf_sel_t'(b));

		cell_ram u_ram (
			.clk(clk),
			.address(back ? wr_addr : rd_addr),
			.data(wr_data),
			.wren(back && wr_en),
			.rden(!back && rden),
			.q(ram_q[b])
		);
	end

	assign q = ram_q[rd_sel];

endmodule

// File: verilog/read_router.sv
/*
 * Read router for the cache grid
 *   Decodes the cell id to a one-hot read enable
 *   Returns the selected cache word one cycle later
 *   Cells outside the grid return zero data
 */
`timescale 1ns/1ns
`include "md_cfg.svh"

module read_router
	import md_types_pkg::*;
#(
	parameter int n_cells = `MD_GRID_X * `MD_GRID_Y * `MD_GRID_Z
)
(
	input logic clk,
	input logic rst,
	input logic rd_en,
	input cell_id_t rd_cell,
	input logic [`MD_ADDR_W-1:0] rd_addr,
	output logic [n_cells-1:0] cache_rden,
	output logic [`MD_ADDR_W-1:0] cache_addr,
	input cache_word_u cache_q [n_cells],
	output cache_word_u rd_data,
	output logic rd_data_valid
);

	localparam int idx_w = (n_cells > 1) ? $clog2(n_cells) : 1;

	logic in_grid;
	logic [idx_w-1:0] idx;
	// Selection held for the cycle the RAM answers
	logic sel_in_grid;
	logic [idx_w-1:0] sel_idx;

	// Cells are numbered from 1 on each axis
	assign in_grid = (rd_cell.cell_x >= 1) && (rd_cell.cell_x <= `MD_GRID_X)
		&& (rd_cell.cell_y >= 1) && (rd_cell.cell_y <= `MD_GRID_Y)
		&& (rd_cell.cell_z >= 1) && (rd_cell.cell_z <= `MD_GRID_Z);

	// x fastest, then y, then z
	assign idx = idx_w'((rd_cell.cell_x - 1)
		+ `MD_GRID_X * ((rd_cell.cell_y - 1) + `MD_GRID_Y * (rd_cell.cell_z - 1)));

	assign cache_rden = (rd_en && in_grid) ? (n_cells'(1) << idx) : '0;
	assign cache_addr = rd_addr;

	always_ff @(posedge clk)
	begin
		if (rst)
			rd_data_valid <= 1'b0;
		else
			rd_data_valid <= rd_en;
		if (rd_en)
		begin
			sel_in_grid <= in_grid;
			sel_idx <= idx;
		end
	end

	assign rd_data = sel_in_grid ? cache_q[sel_idx] : '0;

endmodule

// File: verilog/cell_grid_top.sv
/*
 * Top level of the cell-list position store
 *   Motion update broadcast bus and ready logic
 *   Grid of double-buffered position caches, one per cell
 *   Read router from the single read port to the caches
 */
`timescale 1ns/1ns
`include "md_cfg.svh"

module cell_grid_top
	import md_types_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic mu_enable,
	input logic mu_valid,
	output logic mu_ready,
	input pos_t mu_data,
	input cell_id_t mu_dst_cell,
	input logic rd_en,
	input cell_id_t rd_cell,
	input logic [`MD_ADDR_W-1:0] rd_addr,
	output cache_word_u rd_data,
	output logic rd_data_valid
);

	localparam int n_cells = `MD_GRID_X * `MD_GRID_Y * `MD_GRID_Z;

	logic [n_cells-1:0] cache_rden;
	logic [`MD_ADDR_W-1:0] cache_addr;
	cache_word_u cache_q [n_cells];
	logic [n_cells-1:0] cache_flush;

	//////////////////////////////////////////////////
	// Broadcast bus, source side
	//////////////////////////////////////////////////
	mu_bus_if mu_bus ();

	assign mu_bus.enable = mu_enable;
	// Qualified here so caches never look at ready
	assign mu_bus.beat = mu_valid && mu_ready && mu_enable;
	assign mu_bus.data = mu_data;
	assign mu_bus.dst = mu_dst_cell;

	// Any cache in its flush cycles stalls the bus
	assign mu_ready = ~|cache_flush;

	//////////////////////////////////////////////////
	// Cache grid, x fastest
	//////////////////////////////////////////////////
	for (genvar gz = 0; gz < `MD_GRID_Z; gz++)
	begin : g_z
		for (genvar gy = 0; gy < `MD_GRID_Y; gy++)
		begin : g_y
			for (genvar gx = 0; gx < `MD_GRID_X; gx++)
			begin : g_x
				localparam int idx = gx + `MD_GRID_X * (gy + `MD_GRID_Y * gz);

				pos_cache #(
					.my_x(gx + 1),
					.my_y(gy + 1),
					.my_z(gz + 1)
				) u_cache (
					.clk(clk),
					.rst(rst),
					.mu(mu_bus),
					.rden(cache_rden[idx]),
					.rd_addr(cache_addr),
					.q(cache_q[idx]),
					.flushing(cache_flush[idx])
				);
			end
		end
	end

	// Read path
	read_router #(
		.n_cells(n_cells)
	) u_router (
		.clk(clk),
		.rst(rst),
		.rd_en(rd_en),
		.rd_cell(rd_cell),
		.rd_addr(rd_addr),
		.cache_rden(cache_rden),
		.cache_addr(cache_addr),
		.cache_q(cache_q),
		.rd_data(rd_data),
		.rd_data_valid(rd_data_valid)
	);

endmodule

// File: tests/cell_grid_tb.sv
/*
 * Testbench for the cell grid position store
 *   Clock, reset and input drivers for both buses
 *   Randomized update rounds with a per-cell reference model
 *   Read-back of counts and particles after every swap
 */
`timescale 1ns/1ns
`include "md_cfg.svh"

module cell_grid_tb
	import md_types_pkg::*;
;

	localparam int n_cells = `MD_GRID_X * `MD_GRID_Y * `MD_GRID_Z;
	// Cycles any wait loop may take
	localparam int wait_limit = 100;

	logic clk;
	logic rst;
	logic mu_enable;
	logic mu_valid;
	logic mu_ready;
	pos_t mu_data;
	cell_id_t mu_dst_cell;
	logic rd_en;
	cell_id_t rd_cell;
	logic [`MD_ADDR_W-1:0] rd_addr;
	cache_word_u rd_data;
	logic rd_data_valid;

	// Reference model, positions per cell in arrival order
	pos_t round_q [n_cells][$];
	pos_t image_q [n_cells][$];
	// Beat left valid across a flush
	logic holding;
	pos_t held_pos;
	cell_id_t held_cell;

	cell_grid_top dut_i (
		.clk(clk),
		.rst(rst),
		.mu_enable(mu_enable),
		.mu_valid(mu_valid),
		.mu_ready(mu_ready),
		.mu_data(mu_data),
		.mu_dst_cell(mu_dst_cell),
		.rd_en(rd_en),
		.rd_cell(rd_cell),
		.rd_addr(rd_addr),
		.rd_data(rd_data),
		.rd_data_valid(rd_data_valid)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	//////////////////////////////////////////////////
	// Checking
	//////////////////////////////////////////////////
	task automatic fail_run(input string line);
		$display("%s", line);
		$display("Test FAILED");
		$fatal(1);
	endtask

	task automatic check_value(input string test, input logic [47:0] expected,
		input logic [47:0] actual);
		assert (actual === expected)
		else
			fail_run($sformatf("error in %s: expected %h, actual %h", test, expected, actual));
	endtask

	// Read data comes back one cycle after rd_en, for one cycle only
	assert property (@(posedge clk) disable iff (rst) rd_en |=> rd_data_valid)
	else
		fail_run("rd_data_valid did not follow rd_en by one cycle");
	assert property (@(posedge clk) disable iff (rst) !rd_en |=> !rd_data_valid)
	else
		fail_run("rd_data_valid was high without a read one cycle before");

	//////////////////////////////////////////////////
	// Model helpers
	//////////////////////////////////////////////////
	function automatic cell_id_t make_cell(input int x, input int y, input int z);
		return '{cell_x: `MD_CELL_ID_W'(x), cell_y: `MD_CELL_ID_W'(y),
			cell_z: `MD_CELL_ID_W'(z)};
	endfunction

	// Cells count from 1 on each axis
	function automatic bit inside_grid(input cell_id_t c);
		return c.cell_x >= 1 && c.cell_x <= `MD_GRID_X && c.cell_y >= 1
			&& c.cell_y <= `MD_GRID_Y && c.cell_z >= 1 && c.cell_z <= `MD_GRID_Z;
	endfunction

	function automatic int model_slot(input cell_id_t c);
		return int'(c.cell_x) - 1 + `MD_GRID_X * (int'(c.cell_y) - 1
			+ `MD_GRID_Y * (int'(c.cell_z) - 1));
	endfunction

	function automatic pos_t random_pos();
		return '{z: `MD_COORD_W'($urandom), y: `MD_COORD_W'($urandom),
			x: `MD_COORD_W'($urandom)};
	endfunction

	function automatic cell_id_t random_cell(input bit allow_out);
		cell_id_t c;
		c = make_cell($urandom_range(1, `MD_GRID_X), $urandom_range(1, `MD_GRID_Y),
			$urandom_range(1, `MD_GRID_Z));
		// About one beat in four misses the grid
		if (allow_out && $urandom_range(0, 3) == 0)
		begin
			case ($urandom_range(0, 2))
				0: c.cell_x = `MD_CELL_ID_W'(`MD_GRID_X + 1);
				1: c.cell_y = '0;
				default: c.cell_z = `MD_CELL_ID_W'(`MD_GRID_Z + 1);
			endcase
		end
		return c;
	endfunction

	task automatic record_beat(input pos_t p, input cell_id_t c);
		if (inside_grid(c))
			round_q[model_slot(c)].push_back(p);
	endtask

	//////////////////////////////////////////////////
	// Bus drivers
	//////////////////////////////////////////////////
	// Returns on the rising edge that takes the beat
	task automatic wait_accept();
		int waited;
		waited = 0;
		@(negedge clk);
		while (!(mu_ready && mu_enable))
		begin
			waited++;
			if (waited > wait_limit)
				fail_run("a motion update beat was never accepted");
			@(negedge clk);
		end
		@(posedge clk);
	endtask

	// Called on a rising edge
	task automatic send_beat(input pos_t p, input cell_id_t c);
		mu_valid <= 1'b1;
		mu_data <= p;
		mu_dst_cell <= c;
		wait_accept();
		record_beat(p, c);
	endtask

	task automatic send_round(input int n, input bit allow_out, input bit fixed,
		input cell_id_t fixed_cell);
		int gap;
		for (int i = 0; i < n; i++)
		begin
			send_beat(random_pos(), fixed ? fixed_cell : random_cell(allow_out));
			gap = $urandom_range(0, 2);
			if (gap > 0)
			begin
				mu_valid <= 1'b0;
				repeat (gap) @(posedge clk);
			end
		end
		mu_valid <= 1'b0;
	endtask

	task automatic start_round();
		@(posedge clk);
		mu_enable <= 1'b1;
		// A beat held over the flush opens this round
		if (holding)
		begin
			wait_accept();
			record_beat(held_pos, held_cell);
			mu_valid <= 1'b0;
			holding = 1'b0;
		end
	endtask

	task automatic end_round(input bit hold);
		int waited;
		int low;
		@(posedge clk);
		mu_enable <= 1'b0;
		if (hold)
		begin
			held_pos = random_pos();
			held_cell = random_cell(1'b0);
			mu_valid <= 1'b1;
			mu_data <= held_pos;
			mu_dst_cell <= held_cell;
			holding = 1'b1;
		end
		waited = 0;
		@(negedge clk);
		while (mu_ready)
		begin
			waited++;
			if (waited > wait_limit)
				fail_run("mu_ready never dropped at the end of a round");
			@(negedge clk);
		end
		low = 0;
		while (!mu_ready)
		begin
			low++;
			if (low > wait_limit)
				fail_run("mu_ready stayed low after a round");
			@(negedge clk);
		end
		check_value("flush length", 48'(2), 48'(low));
		// Buffers have swapped, the round becomes the image
		for (int c = 0; c < n_cells; c++)
		begin
			image_q[c] = round_q[c];
			round_q[c].delete();
		end
	endtask

	//////////////////////////////////////////////////
	// Read side
	//////////////////////////////////////////////////
	task automatic read_word(input cell_id_t c, input logic [`MD_ADDR_W-1:0] a,
		output cache_word_u w);
		@(posedge clk);
		rd_en <= 1'b1;
		rd_cell <= c;
		rd_addr <= a;
		@(posedge clk);
		rd_en <= 1'b0;
		@(negedge clk);
		if (!rd_data_valid)
			fail_run("no read data one cycle after a read");
		w = rd_data;
	endtask

	// Count at address 0, then particles in arrival order
	task automatic check_image(input string test);
		cell_id_t cid;
		cache_word_u w;
		int s;
		int n;
		for (int z = 1; z <= `MD_GRID_Z; z++)
			for (int y = 1; y <= `MD_GRID_Y; y++)
				for (int x = 1; x <= `MD_GRID_X; x++)
				begin
					cid = make_cell(x, y, z);
					s = model_slot(cid);
					n = image_q[s].size();
					if (n > `MD_CELL_CAP)
						n = `MD_CELL_CAP;
					read_word(cid, '0, w);
					check_value($sformatf("%s count of cell %0d", test, s), 48'(n), w);
					for (int a = 1; a <= n; a++)
					begin
						read_word(cid, `MD_ADDR_W'(a), w);
						check_value($sformatf("%s cell %0d addr %0d", test, s, a),
							image_q[s][a-1], w);
					end
				end
	endtask

	//////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////
	initial
	begin
		cache_word_u w;
		void'($urandom(17745));
		rst = 1'b1;
		mu_enable = 1'b0;
		mu_valid = 1'b0;
		mu_data = '0;
		mu_dst_cell = '0;
		rd_en = 1'b0;
		rd_cell = '0;
		rd_addr = '0;
		holding = 1'b0;
		repeat (16) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		check_value("ready after reset", 48'(1), 48'(mu_ready));
		check_image("after reset");

		// First round, a beat stays valid across the flush
		start_round();
		fork
			send_round(20, 1'b0, 1'b0, '0);
			check_image("reads during round 1");
		join
		end_round(1'b1);
		check_image("round 1");

		// Second round replaces the first, some beats miss the grid
		start_round();
		fork
			send_round(24, 1'b1, 1'b0, '0);
			check_image("reads during round 2");
		join
		end_round(1'b0);
		check_image("round 2");
		read_word(make_cell(`MD_GRID_X + 1, 1, 1), '0, w);
		check_value("read outside grid x", '0, w);
		read_word(make_cell(1, 0, 1), `MD_ADDR_W'(1), w);
		check_value("read outside grid y", '0, w);
		read_word(make_cell(1, 1, `MD_GRID_Z + 1), '0, w);
		check_value("read outside grid z", '0, w);

		// Overfill one cell
		start_round();
		send_round(`MD_CELL_CAP + 3, 1'b0, 1'b1, make_cell(1, 2, 1));
		send_round(3, 1'b0, 1'b0, '0);
		end_round(1'b0);
		check_image("overflow");

		$display("Test OK");
		$finish;
	end

endmodule

// File: project.f
+incdir+common
common/md_types_pkg.sv
common/cache_ctrl_pkg.sv
common/mu_bus_if.sv
pos_cache/cell_ram.sv
pos_cache/pos_cache.sv
verilog/read_router.sv
verilog/cell_grid_top.sv
tests/cell_grid_tb.sv

// File: Makefile
# Verilator build and run for the cell grid position store

VERILATOR ?= verilator
TOP ?= cell_grid_tb
FILELIST ?= project.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard common/*.svh)
BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf $(OBJ_DIR)
